// File: project.f
+incdir+include
source/ctrlPkg.sv
source/instrDecoder.sv
source/stepSequencer.sv
source/controlEncoder.sv
source/controlUnit.sv
dv/clockGen.sv
dv/controlUnitTb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - include_dirs:
      - include
    files:
      - source/ctrlPkg.sv
      - source/instrDecoder.sv
      - source/stepSequencer.sv
      - source/controlEncoder.sv
      - source/controlUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/clockGen.sv
      - dv/controlUnitTb.sv

// File: dv/controlUnitTb.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module controlUnitTb;

	import ctrlPkg::*;

	localparam int NUM_DISPATCH   = 400;
	localparam int TIMEOUT_CYCLES = NUM_DISPATCH * 13 + 20;
	localparam int PH_INIT  = 0;
	localparam int PH_FETCH = 1;
	localparam int PH_EXEC  = 2;

	logic                    clk;
	logic                    rst;
	logic [`OPCODE_W-1:0]    opcode;
	logic [`FUNCT_W-1:0]     funct;
	logic                    pcWrite;
	logic [`PCSRC_W-1:0]     pcSrc;
	logic                    irWrite;
	logic                    regWrite;
	logic [`REGDST_W-1:0]    regDst;
	logic [`WRITEDATA_W-1:0] writeDataSrc;
	logic [`ALUSRCA_W-1:0]   aluSrcA;
	logic [`ALUSRCB_W-1:0]   aluSrcB;
	aluOp_t                  aluOp;
	logic                    aluOutWrite;
	logic                    aWrite;
	logic                    bWrite;
	logic [`SHIFTLOAD_W-1:0] shiftLoad;
	logic                    shiftAmtSrc;
	logic [`SHIFTCTRL_W-1:0] shiftCtrl;

	// Reference model state
	bit          modelValid;
	int          phase;
	int          idx;
	instrClass_t modelClass;
	int          dispatchCount;
	int          cycleCount;

	logic [31:0] expected [15];
	string       outNames [15];

	clockGen clockGen_i (
		.clk (clk),
		.rst (rst)
	);

	controlUnit controlUnit_i (
		.clk          (clk),
		.rst          (rst),
		.opcode       (opcode),
		.funct        (funct),
		.pcWrite      (pcWrite),
		.pcSrc        (pcSrc),
		.irWrite      (irWrite),
		.regWrite     (regWrite),
		.regDst       (regDst),
		.writeDataSrc (writeDataSrc),
		.aluSrcA      (aluSrcA),
		.aluSrcB      (aluSrcB),
		.aluOp        (aluOp),
		.aluOutWrite  (aluOutWrite),
		.aWrite       (aWrite),
		.bWrite       (bWrite),
		.shiftLoad    (shiftLoad),
		.shiftAmtSrc  (shiftAmtSrc),
		.shiftCtrl    (shiftCtrl)
	);

	function automatic instrClass_t classOf(input logic [5:0] op, input logic [5:0] fn);
		if (op == 6'd8)
			return ClsAddi;
		if (op != 6'd0)
			return ClsNone;
		case (fn)
			6'd32:   return ClsAdd;
			6'd34:   return ClsSub;
			6'd36:   return ClsAnd;
			6'd42:   return ClsSlt;
			6'd0:    return ClsSrl;
			6'd3:    return ClsSra;
			6'd2:    return ClsSll;
			6'd4:    return ClsSllv;
			6'd7:    return ClsSrav;
			6'd8:    return ClsJr;
			6'd13:   return ClsBreak;
			6'd19:   return ClsRte;
			default: return ClsNone;
		endcase
	endfunction

	function automatic int execLength(input instrClass_t cls);
		case (cls)
			ClsAdd, ClsSub, ClsAnd, ClsSlt, ClsJr: return 4;
			ClsAddi:                               return 3;
			ClsSrl, ClsSra, ClsSll, ClsSllv, ClsSrav, ClsBreak:
				return 5;
			ClsRte:                                return 1;
			default:                               return 0;
		endcase
	endfunction

	function automatic logic [5:0] legalFunct(input int sel);
		case (sel)
			0:       return 6'd32;
			1:       return 6'd34;
			2:       return 6'd36;
			3:       return 6'd42;
			4:       return 6'd0;
			5:       return 6'd3;
			6:       return 6'd2;
			7:       return 6'd4;
			8:       return 6'd7;
			9:       return 6'd8;
			10:      return 6'd13;
			default: return 6'd19;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "output mismatch");
		end
	endtask

	// Expected array index order is pcWrite pcSrc irWrite regWrite regDst writeDataSrc
	// aluSrcA aluSrcB aluOp aluOutWrite aWrite bWrite shiftLoad shiftAmtSrc shiftCtrl
	task automatic computeExpected();
		bit immShift;
		immShift = (modelClass == ClsSrl || modelClass == ClsSra || modelClass == ClsSll);
		foreach (expected[i])
			expected[i] = '0;
		if (phase == PH_INIT && idx == 1)
		begin
			expected[3] = 1;
			expected[4] = `REGDST_SP;
			expected[5] = `WD_STACK;
		end
		else if (phase == PH_FETCH && idx == 0)
		begin
			expected[0] = 1;
			expected[7] = `SRCB_FOUR;
			expected[8] = AluAdd;
		end
		else if (phase == PH_FETCH && idx == 2)
		begin
			expected[2] = 1;
		end
		else if (phase == PH_EXEC)
		begin
			case (modelClass)
				ClsAdd, ClsSub, ClsAnd:
				begin
					if (idx == 0)
					begin
						expected[10] = 1;
						expected[11] = 1;
						expected[9]  = 1;
						expected[6]  = `SRCA_A;
						expected[7]  = `SRCB_B;
						expected[8]  = (modelClass == ClsSub) ? AluSub :
							(modelClass == ClsAnd) ? AluAnd : AluAdd;
					end
					else if (idx == 2)
					begin
						expected[3] = 1;
						expected[4] = `REGDST_RD;
						expected[5] = `WD_ALUOUT;
						if (modelClass == ClsSub)
							expected[8] = AluSub;
					end
				end
				ClsAddi:
				begin
					if (idx == 0)
					begin
						expected[10] = 1;
						expected[9]  = 1;
						expected[6]  = `SRCA_A;
						expected[7]  = `SRCB_IMM;
						expected[8]  = AluAdd;
					end
					else if (idx == 2)
					begin
						expected[3] = 1;
						expected[4] = `REGDST_RT;
					end
				end
				ClsSrl, ClsSra, ClsSll, ClsSllv, ClsSrav:
				begin
					if (idx == 0)
					begin
						expected[6]  = `SRCA_A;
						expected[12] = immShift ? `SHLOAD_IMM : `SHLOAD_VAR;
						expected[10] = immShift;
						expected[11] = immShift;
						expected[13] = immShift;
					end
					else if (idx == 1)
					begin
						if (modelClass == ClsSrl)
							expected[14] = `SHIFT_RLOG;
						else if (modelClass == ClsSra || modelClass == ClsSrav)
							expected[14] = `SHIFT_RARI;
						else
							expected[14] = `SHIFT_LEFT;
					end
					else if (idx == 2 || idx == 3)
					begin
						expected[3] = 1;
						expected[4] = `REGDST_RD;
						expected[5] = `WD_SHIFT;
					end
				end
				ClsSlt:
				begin
					if (idx == 0)
					begin
						expected[10] = 1;
						expected[11] = 1;
						expected[6]  = `SRCA_A;
						expected[7]  = `SRCB_B;
						expected[8]  = AluSlt;
					end
					else if (idx == 1 || idx == 2)
					begin
						expected[3] = 1;
						expected[4] = `REGDST_RD;
						expected[5] = `WD_SLT;
					end
				end
				ClsJr:
				begin
					if (idx == 0)
					begin
						expected[6] = `SRCA_JR;
						expected[7] = `SRCB_ZERO;
						expected[8] = AluAdd;
						expected[9] = 1;
					end
					else if (idx == 1 || idx == 2)
					begin
						expected[0] = 1;
						expected[1] = `PCSRC_ALUOUT;
					end
				end
				ClsBreak:
				begin
					if (idx == 0)
					begin
						expected[10] = 1;
						expected[11] = 1;
						expected[6]  = `SRCA_PC;
						expected[7]  = `SRCB_FOUR;
						expected[8]  = AluSub;
					end
					else if (idx >= 1 && idx <= 3)
					begin
						expected[0] = 1;
						expected[1] = `PCSRC_ALU;
					end
				end
				ClsRte:
				begin
					expected[0] = 1;
					expected[1] = `PCSRC_EPC;
				end
				default: ;
			endcase
		end
	endtask

	task automatic compareOutputs();
		logic [31:0] actual [15];
		actual = '{pcWrite, pcSrc, irWrite, regWrite, regDst, writeDataSrc, aluSrcA,
			aluSrcB, aluOp, aluOutWrite, aWrite, bWrite, shiftLoad, shiftAmtSrc, shiftCtrl};
		foreach (actual[i])
			checkValue(outNames[i], expected[i], actual[i]);
	endtask

	task automatic advanceModel();
		instrClass_t cls;
		case (phase)
			PH_INIT:
			begin
				if (idx == 2)
				begin
					phase = PH_FETCH;
					idx   = 0;
				end
				else
					idx++;
			end
			PH_FETCH:
			begin
				if (idx == 4)
				begin
					// Dispatch samples the fields
					cls = classOf(opcode, funct);
					dispatchCount++;
					idx = 0;
					if (execLength(cls) != 0)
					begin
						phase      = PH_EXEC;
						modelClass = cls;
					end
				end
				else
					idx++;
			end
			default:
			begin
				if (idx == execLength(modelClass) - 1)
				begin
					phase = PH_FETCH;
					idx   = 0;
				end
				else
					idx++;
			end
		endcase
	endtask

	task automatic driveRandomInstr();
		int unsigned pick;
		logic [31:0] rnd;
		pick = $urandom_range(99);
		rnd  = $urandom;
		if (pick < 80)
		begin
			pick = $urandom_range(12);
			if (pick == 12)
			begin
				opcode = 6'd8;
				funct  = rnd[5:0];
			end
			else
			begin
				opcode = 6'd0;
				funct  = legalFunct(pick);
			end
		end
		else
		begin
			opcode = rnd[5:0];
			funct  = rnd[13:8];
		end
	endtask

	initial
	begin
		bit finished;
		void'($urandom(43));
		opcode        = '0;
		funct         = '0;
		modelValid    = 0;
		phase         = PH_INIT;
		idx           = 0;
		modelClass    = ClsNone;
		dispatchCount = 0;
		cycleCount    = 0;
		finished      = 0;
		outNames = '{"pcWrite", "pcSrc", "irWrite", "regWrite", "regDst", "writeDataSrc",
			"aluSrcA", "aluSrcB", "aluOp", "aluOutWrite", "aWrite", "bWrite", "shiftLoad",
			"shiftAmtSrc", "shiftCtrl"};
		while (!finished)
		begin
			// Outputs are settled by the falling edge
			@(negedge clk);
			if (modelValid)
			begin
				computeExpected();
				compareOutputs();
			end
			if (modelValid && dispatchCount >= NUM_DISPATCH && phase == PH_FETCH && idx == 0)
				finished = 1;
			else
				driveRandomInstr();
		end
		$display("Simulation completed successfully");
		$finish;
	end

	always @(posedge clk)
	begin
		if (rst)
		begin
			modelValid = 1;
			phase      = PH_INIT;
			idx        = 0;
		end
		else if (modelValid)
			advanceModel();
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout before all instructions completed");
			$display("Simulation failed");
			$fatal(1, "cycle limit reached");
		end
	end

endmodule

// File: dv/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held over the first three rising edges
	initial
	begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: source/controlUnit.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module controlUnit (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`OPCODE_W-1:0]     opcode,
	input  logic [`FUNCT_W-1:0]      funct,
	output logic                     pcWrite,
	output logic [`PCSRC_W-1:0]      pcSrc,
	output logic                     irWrite,
	output logic                     regWrite,
	output logic [`REGDST_W-1:0]     regDst,
	output logic [`WRITEDATA_W-1:0]  writeDataSrc,
	output logic [`ALUSRCA_W-1:0]    aluSrcA,
	output logic [`ALUSRCB_W-1:0]    aluSrcB,
	output ctrlPkg::aluOp_t          aluOp,
	output logic                     aluOutWrite,
	output logic                     aWrite,
	output logic                     bWrite,
	output logic [`SHIFTLOAD_W-1:0]  shiftLoad,
	output logic                     shiftAmtSrc,
	output logic [`SHIFTCTRL_W-1:0]  shiftCtrl
);

	import ctrlPkg::*;

	instrClass_t instrClass;
	instrClass_t curClass;
	ctrlStep_t   step;

	instrDecoder instrDecoder_i (
		.opcode     (opcode),
		.funct      (funct),
		.instrClass (instrClass)
	);

	stepSequencer stepSequencer_i (
		.clk        (clk),
		.rst        (rst),
		.instrClass (instrClass),
		.step       (step),
		.curClass   (curClass)
	);

	// Outputs follow step and captured class only
	controlEncoder controlEncoder_i (
		.step         (step),
		.curClass     (curClass),
		.pcWrite      (pcWrite),
		.pcSrc        (pcSrc),
		.irWrite      (irWrite),
		.regWrite     (regWrite),
		.regDst       (regDst),
		.writeDataSrc (writeDataSrc),
		.aluSrcA      (aluSrcA),
		.aluSrcB      (aluSrcB),
		.aluOp        (aluOp),
		.aluOutWrite  (aluOutWrite),
		.aWrite       (aWrite),
		.bWrite       (bWrite),
		.shiftLoad    (shiftLoad),
		.shiftAmtSrc  (shiftAmtSrc),
		.shiftCtrl    (shiftCtrl)
	);

endmodule

// File: source/controlEncoder.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module controlEncoder (
	input  ctrlPkg::ctrlStep_t       step,
	input  ctrlPkg::instrClass_t     curClass,
	output logic                     pcWrite,
	output logic [`PCSRC_W-1:0]      pcSrc,
	output logic                     irWrite,
	output logic                     regWrite,
	output logic [`REGDST_W-1:0]     regDst,
	output logic [`WRITEDATA_W-1:0]  writeDataSrc,
	output logic [`ALUSRCA_W-1:0]    aluSrcA,
	output logic [`ALUSRCB_W-1:0]    aluSrcB,
	output ctrlPkg::aluOp_t          aluOp,
	output logic                     aluOutWrite,
	output logic                     aWrite,
	output logic                     bWrite,
	output logic [`SHIFTLOAD_W-1:0]  shiftLoad,
	output logic                     shiftAmtSrc,
	output logic [`SHIFTCTRL_W-1:0]  shiftCtrl
);

	import ctrlPkg::*;

	always_comb
	begin
		// Anything a step does not name stays low
		pcWrite      = 1'b0;
		pcSrc        = '0;
		irWrite      = 1'b0;
		regWrite     = 1'b0;
		regDst       = '0;
		writeDataSrc = '0;
		aluSrcA      = '0;
		aluSrcB      = '0;
		aluOp        = AluNone;
		aluOutWrite  = 1'b0;
		aWrite       = 1'b0;
		bWrite       = 1'b0;
		shiftLoad    = '0;
		shiftAmtSrc  = 1'b0;
		shiftCtrl    = '0;

		case (step)
			StInitSp:
			begin
				regWrite     = 1'b1;
				regDst       = `REGDST_SP;
				writeDataSrc = `WD_STACK;
			end
			StFetch:
			begin
				// PC + 4
				pcWrite = 1'b1;
				aluSrcB = `SRCB_FOUR;
				aluOp   = AluAdd;
			end
			StIrLoad:
			begin
				irWrite = 1'b1;
			end
			StAluExec:
			begin
				aWrite      = 1'b1;
				bWrite      = 1'b1;
				aluOutWrite = 1'b1;
				aluSrcA     = `SRCA_A;
				aluSrcB     = `SRCB_B;
				case (curClass)
					ClsSub:  aluOp = AluSub;
					ClsAnd:  aluOp = AluAnd;
					default: aluOp = AluAdd;
				endcase
			end
			StAluWrite:
			begin
				regWrite     = 1'b1;
				regDst       = `REGDST_RD;
				writeDataSrc = `WD_ALUOUT;
				if (curClass == ClsSub)
				begin
					aluOp = AluSub;
				end
			end
			StImmExec:
			begin
				aWrite      = 1'b1;
				aluOutWrite = 1'b1;
				aluSrcA     = `SRCA_A;
				aluSrcB     = `SRCB_IMM;
				aluOp       = AluAdd;
			end
			StImmWrite:
			begin
				regWrite     = 1'b1;
				regDst       = `REGDST_RT;
				writeDataSrc = `WD_ALUOUT;
			end
			StShLoad:
			begin
				aluSrcA = `SRCA_A;
				if (curClass == ClsSllv || curClass == ClsSrav)
				begin
					shiftLoad = `SHLOAD_VAR;
				end
				else
				begin
					// Amount from the shamt field
					aWrite      = 1'b1;
					bWrite      = 1'b1;
					shiftLoad   = `SHLOAD_IMM;
					shiftAmtSrc = 1'b1;
				end
			end
			StShRun:
			begin
				case (curClass)
					ClsSrl:          shiftCtrl = `SHIFT_RLOG;
					ClsSra, ClsSrav: shiftCtrl = `SHIFT_RARI;
					ClsSll, ClsSllv: shiftCtrl = `SHIFT_LEFT;
					default:         shiftCtrl = '0;
				endcase
			end
			StShWrite, StShHold:
			begin
				regWrite     = 1'b1;
				regDst       = `REGDST_RD;
				writeDataSrc = `WD_SHIFT;
			end
			StSltExec:
			begin
				aWrite  = 1'b1;
				bWrite  = 1'b1;
				aluSrcA = `SRCA_A;
				aluSrcB = `SRCB_B;
				aluOp   = AluSlt;
			end
			StSltWrite, StSltHold:
			begin
				regWrite     = 1'b1;
				regDst       = `REGDST_RD;
				writeDataSrc = `WD_SLT;
			end
			StJrCalc:
			begin
				aluSrcA     = `SRCA_JR;
				aluSrcB     = `SRCB_ZERO;
				aluOp       = AluAdd;
				aluOutWrite = 1'b1;
			end
			StJrJump, StJrHold:
			begin
				pcWrite = 1'b1;
				pcSrc   = `PCSRC_ALUOUT;
			end
			StBrkCalc:
			begin
				// PC - 4 back onto the break
				aWrite  = 1'b1;
				bWrite  = 1'b1;
				aluSrcA = `SRCA_PC;
				aluSrcB = `SRCB_FOUR;
				aluOp   = AluSub;
			end
			StBrkJump, StBrkHold1, StBrkHold2:
			begin
				pcWrite = 1'b1;
				pcSrc   = `PCSRC_ALU;
			end
			StRteJump:
			begin
				pcWrite = 1'b1;
				pcSrc   = `PCSRC_EPC;
			end
			default: ;
		endcase
	end

endmodule

// File: source/stepSequencer.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module stepSequencer (
	input  logic                 clk,
	input  logic                 rst,
	input  ctrlPkg::instrClass_t instrClass,
	output ctrlPkg::ctrlStep_t   step,
	output ctrlPkg::instrClass_t curClass
);

	import ctrlPkg::*;

	ctrlStep_t nextStep;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			step     <= StInit;
			curClass <= ClsNone;
		end
		else
		begin
			step <= nextStep;
			// Class only sampled on leaving dispatch
			if (step == StDispatch)
			begin
				curClass <= instrClass;
			end
		end
	end

	always_comb
	begin
		nextStep = StFetch;
		case (step)
			StInit:       nextStep = StInitSp;
			StInitSp:     nextStep = StInitIdle;
			StInitIdle:   nextStep = StFetch;
			StFetch:      nextStep = StFetchWait;
			StFetchWait:  nextStep = StIrLoad;
			StIrLoad:     nextStep = StDecodeWait;
			StDecodeWait: nextStep = StDispatch;
			StDispatch:
			begin
				case (instrClass)
					ClsAdd, ClsSub, ClsAnd:
						nextStep = StAluExec;
					ClsAddi:
						nextStep = StImmExec;
					ClsSrl, ClsSra, ClsSll, ClsSllv, ClsSrav:
						nextStep = StShLoad;
					ClsSlt:
						nextStep = StSltExec;
					ClsJr:
						nextStep = StJrCalc;
					ClsBreak:
						nextStep = StBrkCalc;
					ClsRte:
						nextStep = StRteJump;
					// Unknown encoding goes back to fetch
					default:
						nextStep = StFetch;
				endcase
			end
			StAluExec:    nextStep = StAluWait;
			StAluWait:    nextStep = StAluWrite;
			StAluWrite:   nextStep = StAluDone;
			StImmExec:    nextStep = StImmWait;
			StImmWait:    nextStep = StImmWrite;
			StShLoad:     nextStep = StShRun;
			StShRun:      nextStep = StShWrite;
			StShWrite:    nextStep = StShHold;
			StShHold:     nextStep = StShDone;
			StSltExec:    nextStep = StSltWrite;
			StSltWrite:   nextStep = StSltHold;
			StSltHold:    nextStep = StSltDone;
			StJrCalc:     nextStep = StJrJump;
			StJrJump:     nextStep = StJrHold;
			StJrHold:     nextStep = StJrDone;
			StBrkCalc:    nextStep = StBrkJump;
			StBrkJump:    nextStep = StBrkHold1;
			StBrkHold1:   nextStep = StBrkHold2;
			StBrkHold2:   nextStep = StBrkDone;
			// Last step of every sequence
			default:      nextStep = StFetch;
		endcase
	end

endmodule

// File: source/instrDecoder.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module instrDecoder (
	input  logic [`OPCODE_W-1:0] opcode,
	input  logic [`FUNCT_W-1:0]  funct,
	output ctrlPkg::instrClass_t instrClass
);

	import ctrlPkg::*;

	always_comb
	begin
		instrClass = ClsNone;
		case (opcode)
			OpAddi:
			begin
				instrClass = ClsAddi;
			end
			OpRType:
			begin
				// R-type class comes from the function field
				case (funct)
					FnAdd:   instrClass = ClsAdd;
					FnSub:   instrClass = ClsSub;
					FnAnd:   instrClass = ClsAnd;
					FnSlt:   instrClass = ClsSlt;
					FnSrl:   instrClass = ClsSrl;
					FnSra:   instrClass = ClsSra;
					FnSll:   instrClass = ClsSll;
					FnSllv:  instrClass = ClsSllv;
					FnSrav:  instrClass = ClsSrav;
					FnJr:    instrClass = ClsJr;
					FnBreak: instrClass = ClsBreak;
					FnRte:   instrClass = ClsRte;
					default: instrClass = ClsNone;
				endcase
			end
			default:
			begin
				instrClass = ClsNone;
			end
		endcase
	end

endmodule

// File: source/ctrlPkg.sv
`include "ctrl_cfg.svh"

package ctrlPkg;

	typedef enum logic [`OPCODE_W-1:0] {
		OpRType = 6'd0,
		OpAddi  = 6'd8
	} opcode_t;

	// Function field under OpRType
	typedef enum logic [`FUNCT_W-1:0] {
		FnSrl   = 6'd0,
		FnSll   = 6'd2,
		FnSra   = 6'd3,
		FnSllv  = 6'd4,
		FnSrav  = 6'd7,
		FnJr    = 6'd8,
		FnBreak = 6'd13,
		FnRte   = 6'd19,
		FnAdd   = 6'd32,
		FnSub   = 6'd34,
		FnAnd   = 6'd36,
		FnSlt   = 6'd42
	} funct_t;

	typedef enum logic [`ALUOP_W-1:0] {
		AluNone = 3'd0,
		AluAdd  = 3'd1,
		AluSub  = 3'd2,
		AluAnd  = 3'd3,
		AluSlt  = 3'd7
	} aluOp_t;

	typedef enum logic [3:0] {
		ClsNone, ClsAdd, ClsSub, ClsAnd, ClsSlt, ClsAddi, ClsSrl,
		ClsSra, ClsSll, ClsSllv, ClsSrav, ClsJr, ClsBreak, ClsRte
	} instrClass_t;

	// Sequencer steps, grouped by execute sequence
	typedef enum logic [5:0] {
		StInit, StInitSp, StInitIdle,
		StFetch, StFetchWait, StIrLoad, StDecodeWait, StDispatch,
		StAluExec, StAluWait, StAluWrite, StAluDone,
		StImmExec, StImmWait, StImmWrite,
		StShLoad, StShRun, StShWrite, StShHold, StShDone,
		StSltExec, StSltWrite, StSltHold, StSltDone,
		StJrCalc, StJrJump, StJrHold, StJrDone,
		StBrkCalc, StBrkJump, StBrkHold1, StBrkHold2, StBrkDone,
		StRteJump
	} ctrlStep_t;

endpackage

// File: include/ctrl_cfg.svh
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// Instruction field widths
`define OPCODE_W     6
`define FUNCT_W      6

// Control output widths
`define ALUSRCA_W    3
`define ALUSRCB_W    3
`define ALUOP_W      3
`define SHIFTCTRL_W  3
`define REGDST_W     2
`define PCSRC_W      2
`define SHIFTLOAD_W  2
`define WRITEDATA_W  4

// Register destination select
`define REGDST_RT    2'd0
`define REGDST_RD    2'd1
`define REGDST_SP    2'd3

// PC source select
`define PCSRC_ALU    2'd0
`define PCSRC_EPC    2'd1
`define PCSRC_ALUOUT 2'd2

// ALU operand A select
`define SRCA_PC      3'd0
`define SRCA_JR      3'd3
`define SRCA_A       3'd4

// ALU operand B select
`define SRCB_B       3'd0
`define SRCB_FOUR    3'd1
`define SRCB_IMM     3'd2
`define SRCB_ZERO    3'd5

// Shift amount load
`define SHLOAD_VAR   2'd1
`define SHLOAD_IMM   2'd2

// Shifter operation
`define SHIFT_LEFT   3'd2
`define SHIFT_RLOG   3'd3
`define SHIFT_RARI   3'd4

// Register file write data select
`define WD_ALUOUT    4'd0
`define WD_SLT       4'd3
`define WD_SHIFT     4'd4
`define WD_STACK     4'd8

`endif
